// ==== Bender.yml ====
package:
  name: cpu_exec_slice

sources:
  - cpu_pkg.sv
  - stage_if.sv
  - control.sv
  - reg_file.sv
  - id_ex_reg.sv
  - execute_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_top.sv

// ==== control.sv ====
`default_nettype none

module control (
	input  cpu_pkg::opcode_e  opcode,
	input  cpu_pkg::funcode_e funcode,
	output cpu_pkg::ctrl_t    ctrl
);

	always_comb begin
		// Start from an empty bundle
		ctrl = '0;

		// Every decoded word counts as an instruction
		ctrl.is_inst = 1'b1;

		// ALU sees the raw codes
		ctrl.opcode = opcode;
		ctrl.funcode = funcode;

		case (opcode)
			// Immediate arithmetic and LHI
			cpu_pkg::op_adi,
			cpu_pkg::op_ori,
			cpu_pkg::op_lhi: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
			end

			// Load into rt
			cpu_pkg::op_lwd: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.alu_src = 1'b1;
			end

			// Store rt, address through ALU
			cpu_pkg::op_swd: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src = 1'b1;
			end

			cpu_pkg::op_rtype: begin
				// Destination is rd
				ctrl.reg_dest = 1'b1;
				case (funcode)
					cpu_pkg::fn_add,
					cpu_pkg::fn_sub,
					cpu_pkg::fn_and,
					cpu_pkg::fn_orr,
					cpu_pkg::fn_not,
					cpu_pkg::fn_tcp,
					cpu_pkg::fn_shl,
					cpu_pkg::fn_shr: begin
						ctrl.reg_write = 1'b1;
					end
					// Output port only, no register write
					cpu_pkg::fn_wwd: begin
						ctrl.is_wwd = 1'b1;
					end
					cpu_pkg::fn_hlt: begin
						ctrl.is_halt = 1'b1;
					end
					// JPR, JRL and unknown funcodes
					default: begin
						ctrl.reg_write = 1'b0;
					end
				endcase
			end

			// Branches, jumps and unused opcodes pass as bubbles
			default: begin
				ctrl.reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Datapath and instruction width, fixed by the ISA
	localparam int word_width = 16;

	// Register file geometry
	localparam int reg_count = 4;
	localparam int reg_addr_width = 2;

	// Data memory geometry
	localparam int dmem_depth = 16;
	localparam int dmem_addr_width = 4;

	// Instruction field widths
	localparam int opcode_width = 4;
	localparam int funcode_width = 6;
	localparam int imm_width = 8;

	// Major opcodes in inst[15:12]
	typedef enum logic [opcode_width-1:0] {
		// Branches, not executed here
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_bgz = 4'd2,
		op_blz = 4'd3,
		// I-type
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		// Jumps, not executed here
		op_jmp = 4'd9,
		op_jal = 4'd10,
		// Everything selected by funcode
		op_rtype = 4'd15
	} opcode_e;

	// Function codes in inst[5:0] for op_rtype
	typedef enum logic [funcode_width-1:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} funcode_e;

	// Control bundle, grouped by the stage that consumes it
	typedef struct packed {
		// WB group
		logic is_inst;
		logic is_halt;
		logic is_wwd;
		logic reg_write;
		logic mem_to_reg;
		// M group
		logic mem_read;
		logic mem_write;
		// EX group
		opcode_e opcode;
		funcode_e funcode;
		logic alu_src;
		// ID group, high selects rd over rt
		logic reg_dest;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== cpu_top.sv ====
`default_nettype none

module cpu_top (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               inst_valid,
	input  logic [cpu_pkg::word_width-1:0]     inst,
	output logic                               wb_valid,
	output logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
	output logic [cpu_pkg::word_width-1:0]     wb_data,
	output logic                               out_valid,
	output logic [cpu_pkg::word_width-1:0]     out_data,
	output logic                               halted
);

	// Register file write port, from the write-back latch
	logic                               we;
	logic [cpu_pkg::reg_addr_width-1:0] wr_addr;
	logic [cpu_pkg::word_width-1:0]     wr_data;

	// Decode side and execute side of the stage register
	stage_if dec_bus ();
	stage_if ex_bus ();

	// Opcode and funcode straight from the instruction word
	control u_control (
		.opcode  (cpu_pkg::opcode_e'(inst[15:12])),
		.funcode (cpu_pkg::funcode_e'(inst[5:0])),
		.ctrl    (dec_bus.ctrl)
	);

	// Read addresses come from field extraction in the stage register
	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rs_addr (dec_bus.rs),
		.rt_addr (dec_bus.rt),
		.rs_data (dec_bus.op_a),
		.rt_data (dec_bus.op_b),
		.we      (we),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	id_ex_reg u_id_ex_reg (
		.clk        (clk),
		.rst        (rst),
		.inst       (inst),
		.inst_valid (inst_valid),
		.dec_bus    (dec_bus),
		.ex_bus     (ex_bus)
	);

	execute_stage u_execute_stage (
		.clk       (clk),
		.rst       (rst),
		.ex_bus    (ex_bus),
		.we        (we),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.halted    (halted)
	);

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none

module execute_stage (
	input  logic                               clk,
	input  logic                               rst,
	stage_if.dst                               ex_bus,
	output logic                               we,
	output logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
	output logic [cpu_pkg::word_width-1:0]     wr_data,
	output logic                               wb_valid,
	output logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
	output logic [cpu_pkg::word_width-1:0]     wb_data,
	output logic                               out_valid,
	output logic [cpu_pkg::word_width-1:0]     out_data,
	output logic                               halted
);

	localparam int ext_width = cpu_pkg::word_width - cpu_pkg::imm_width;

	// Write-back latch
	logic                               wb_we_q;
	logic                               out_valid_q;
	logic [cpu_pkg::reg_addr_width-1:0] wb_reg_q;
	logic [cpu_pkg::word_width-1:0]     wb_data_q;
	logic                               halted_q;

	logic                               live;
	logic [cpu_pkg::word_width-1:0]     fwd_a;
	logic [cpu_pkg::word_width-1:0]     fwd_b;
	logic [cpu_pkg::word_width-1:0]     imm_ext;
	logic [cpu_pkg::word_width-1:0]     src_b;
	logic [cpu_pkg::word_width-1:0]     alu_y;
	logic [cpu_pkg::dmem_addr_width-1:0] mem_addr;
	logic [cpu_pkg::word_width-1:0]     mem_rdata;
	logic [cpu_pkg::word_width-1:0]     result;

	logic [cpu_pkg::word_width-1:0] dmem [cpu_pkg::dmem_depth];

	// Nothing retires once halted
	assign live = ex_bus.valid && ex_bus.ctrl.is_inst && !halted_q;

	// Forward from the previous instruction, still in the latch
	assign fwd_a = (wb_we_q && wb_reg_q == ex_bus.rs) ? wb_data_q : ex_bus.op_a;
	assign fwd_b = (wb_we_q && wb_reg_q == ex_bus.rt) ? wb_data_q : ex_bus.op_b;

	// ORI zero-extends, other immediates sign-extend
	assign imm_ext = (ex_bus.ctrl.opcode == cpu_pkg::op_ori)
		? {{ext_width{1'b0}}, ex_bus.imm8}
		: {{ext_width{ex_bus.imm8[cpu_pkg::imm_width-1]}}, ex_bus.imm8};

	assign src_b = ex_bus.ctrl.alu_src ? imm_ext : fwd_b;

	always_comb begin
		alu_y = '0;
		case (ex_bus.ctrl.opcode)
			// Add also forms the load/store address
			cpu_pkg::op_adi,
			cpu_pkg::op_lwd,
			cpu_pkg::op_swd: alu_y = fwd_a + src_b;
			cpu_pkg::op_ori: alu_y = fwd_a | src_b;
			// Immediate into the upper byte
			cpu_pkg::op_lhi: alu_y = {ex_bus.imm8, {ext_width{1'b0}}};
			cpu_pkg::op_rtype: begin
				case (ex_bus.ctrl.funcode)
					cpu_pkg::fn_add: alu_y = fwd_a + src_b;
					cpu_pkg::fn_sub: alu_y = fwd_a - src_b;
					cpu_pkg::fn_and: alu_y = fwd_a & src_b;
					cpu_pkg::fn_orr: alu_y = fwd_a | src_b;
					cpu_pkg::fn_not: alu_y = ~fwd_a;
					cpu_pkg::fn_tcp: alu_y = ~fwd_a + 1'b1;
					cpu_pkg::fn_shl: alu_y = fwd_a << 1;
					// Arithmetic shift keeps the sign
					cpu_pkg::fn_shr: alu_y = $signed(fwd_a) >>> 1;
					// WWD passes rs through to the output
					cpu_pkg::fn_wwd: alu_y = fwd_a;
					default: alu_y = '0;
				endcase
			end
			default: alu_y = '0;
		endcase
	end

	// Low address bits only, memory wraps
	assign mem_addr = alu_y[cpu_pkg::dmem_addr_width-1:0];
	assign mem_rdata = ex_bus.ctrl.mem_read ? dmem[mem_addr] : '0;
	assign result = ex_bus.ctrl.mem_to_reg ? mem_rdata : alu_y;

	// Data memory, store data is forwarded rt
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::dmem_depth; i++) begin
				dmem[i] <= '0;
			end
		end else if (live && ex_bus.ctrl.mem_write) begin
			dmem[mem_addr] <= fwd_b;
		end
	end

	// Strobes and halt state
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we_q <= 1'b0;
			out_valid_q <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			wb_we_q <= live && ex_bus.ctrl.reg_write;
			out_valid_q <= live && ex_bus.ctrl.is_wwd;
			// Sticky until reset
			halted_q <= halted_q || (live && ex_bus.ctrl.is_halt);
		end
	end

	// Latch payload
	always_ff @(posedge clk) begin
		wb_reg_q <= ex_bus.dest;
		wb_data_q <= result;
	end

	// Register file write one edge after the latch loads
	assign we = wb_we_q;
	assign wr_addr = wb_reg_q;
	assign wr_data = wb_data_q;

	// Top-level view of the same latch
	assign wb_valid = wb_we_q;
	assign wb_reg = wb_reg_q;
	assign wb_data = wb_data_q;
	assign out_valid = out_valid_q;
	assign out_data = wb_data_q;
	assign halted = halted_q;

endmodule

`default_nettype wire

// ==== id_ex_reg.sv ====
`default_nettype none

module id_ex_reg (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [cpu_pkg::word_width-1:0] inst,
	input  logic                           inst_valid,
	stage_if.src                           dec_bus,
	stage_if.drv                           ex_bus
);

	// Field extraction on the decode side
	assign dec_bus.valid = inst_valid;
	assign dec_bus.rs = inst[11:10];
	assign dec_bus.rt = inst[9:8];
	assign dec_bus.imm8 = inst[7:0];

	// rd for R-type, rt for I-type
	assign dec_bus.dest = dec_bus.ctrl.reg_dest ? inst[7:6] : inst[9:8];

	// Slot occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_bus.valid <= 1'b0;
		end else begin
			ex_bus.valid <= dec_bus.valid;
		end
	end

	// Payload, taken every cycle
	always_ff @(posedge clk) begin
		ex_bus.ctrl <= dec_bus.ctrl;
		ex_bus.op_a <= dec_bus.op_a;
		ex_bus.op_b <= dec_bus.op_b;
		ex_bus.rs <= dec_bus.rs;
		ex_bus.rt <= dec_bus.rt;
		ex_bus.dest <= dec_bus.dest;
		ex_bus.imm8 <= dec_bus.imm8;
	end

endmodule

`default_nettype wire

// ==== project.f ====
cpu_pkg.sv
stage_if.sv
control.sv
reg_file.sv
id_ex_reg.sv
execute_stage.sv
cpu_top.sv
tb_checker.sv
tb_top.sv

// ==== reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [cpu_pkg::reg_addr_width-1:0] rs_addr,
	input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
	output logic [cpu_pkg::word_width-1:0]     rs_data,
	output logic [cpu_pkg::word_width-1:0]     rt_data,
	input  logic                               we,
	input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
	input  logic [cpu_pkg::word_width-1:0]     wr_data
);

	logic [cpu_pkg::word_width-1:0] regs [cpu_pkg::reg_count];

	// Registers come up as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through covers a write two instructions back
	assign rs_data = (we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// ==== stage_if.sv ====
`default_nettype none

interface stage_if;

	// Instruction present in this slot
	logic valid;
	cpu_pkg::ctrl_t ctrl;

	// Register operands, rs and rt values
	logic [cpu_pkg::word_width-1:0] op_a;
	logic [cpu_pkg::word_width-1:0] op_b;

	// Register numbers for forwarding and write-back
	logic [cpu_pkg::reg_addr_width-1:0] rs;
	logic [cpu_pkg::reg_addr_width-1:0] rt;
	logic [cpu_pkg::reg_addr_width-1:0] dest;

	// Raw immediate, extended in execute
	logic [cpu_pkg::imm_width-1:0] imm8;

	// Decode side as seen by the stage register
	// Control and operands come in, field extraction goes out
	modport src (input ctrl, op_a, op_b, output valid, rs, rt, dest, imm8);

	// Stage register output
	modport drv (output valid, ctrl, op_a, op_b, rs, rt, dest, imm8);

	// Execute side
	modport dst (input valid, ctrl, op_a, op_b, rs, rt, dest, imm8);

endinterface

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               inst_valid,
	input  logic [cpu_pkg::word_width-1:0]     inst,
	input  logic                               wb_valid,
	input  logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
	input  logic [cpu_pkg::word_width-1:0]     wb_data,
	input  logic                               out_valid,
	input  logic [cpu_pkg::word_width-1:0]     out_data,
	input  logic                               halted,
	output int                                 mismatches,
	output int                                 other_errors
);

	// ISA state, updated in program order
	logic [cpu_pkg::word_width-1:0] regs [cpu_pkg::reg_count];
	logic [cpu_pkg::word_width-1:0] dmem [cpu_pkg::dmem_depth];
	logic model_halted;

	// Result of the instruction sampled on the last edge
	logic pend_wb;
	logic pend_out;
	logic pend_halted;
	logic [cpu_pkg::reg_addr_width-1:0] pend_reg;
	logic [cpu_pkg::word_width-1:0] pend_data;

	// What the DUT should show right now
	logic exp_wb;
	logic exp_out;
	logic exp_halted;
	logic [cpu_pkg::reg_addr_width-1:0] exp_reg;
	logic [cpu_pkg::word_width-1:0] exp_data;

	initial begin
		mismatches = 0;
		other_errors = 0;
	end

	task automatic set_reg(input logic [1:0] r, input logic [15:0] v);
		regs[r] = v;
		pend_wb = 1'b1;
		pend_reg = r;
		pend_data = v;
	endtask

	// One instruction through the reference model
	task automatic apply_inst(input logic [15:0] w);
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] simm;
		logic [3:0] addr;
		rs = w[11:10];
		rt = w[9:8];
		rd = w[7:6];
		a = regs[rs];
		b = regs[rt];
		simm = {{8{w[7]}}, w[7:0]};
		addr = a[3:0] + simm[3:0];
		case (w[15:12])
			cpu_pkg::op_adi: set_reg(rt, a + simm);
			cpu_pkg::op_ori: set_reg(rt, a | {8'h00, w[7:0]});
			cpu_pkg::op_lhi: set_reg(rt, {w[7:0], 8'h00});
			cpu_pkg::op_lwd: set_reg(rt, dmem[addr]);
			cpu_pkg::op_swd: dmem[addr] = b;
			cpu_pkg::op_rtype: begin
				case (w[5:0])
					cpu_pkg::fn_add: set_reg(rd, a + b);
					cpu_pkg::fn_sub: set_reg(rd, a - b);
					cpu_pkg::fn_and: set_reg(rd, a & b);
					cpu_pkg::fn_orr: set_reg(rd, a | b);
					cpu_pkg::fn_not: set_reg(rd, ~a);
					cpu_pkg::fn_tcp: set_reg(rd, 16'd0 - a);
					cpu_pkg::fn_shl: set_reg(rd, {a[14:0], 1'b0});
					cpu_pkg::fn_shr: set_reg(rd, {a[15], a[15:1]});
					cpu_pkg::fn_wwd: begin
						pend_out = 1'b1;
						pend_data = a;
					end
					cpu_pkg::fn_hlt: model_halted = 1'b1;
					// Jumps and unknown funcodes leave no trace
					default: ;
				endcase
			end
			// Branches and jumps retire as bubbles
			default: ;
		endcase
	endtask

	task automatic check_word(input string name, input logic [15:0] act, input logic [15:0] exp);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
			mismatches++;
		end
	endtask

	// Inputs were driven on the falling edge, so they are settled here
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] = '0;
			end
			for (int i = 0; i < cpu_pkg::dmem_depth; i++) begin
				dmem[i] = '0;
			end
			model_halted = 1'b0;
			{pend_wb, pend_out, pend_halted, pend_reg, pend_data} = '0;
			{exp_wb, exp_out, exp_halted, exp_reg, exp_data} = '0;
		end else begin
			exp_wb = pend_wb;
			exp_out = pend_out;
			exp_halted = pend_halted;
			exp_reg = pend_reg;
			exp_data = pend_data;
			pend_wb = 1'b0;
			pend_out = 1'b0;
			if (inst_valid && !model_halted) begin
				apply_inst(inst);
			end
			pend_halted = model_halted;
		end
	end

	// Outputs change on the rising edge and are compared half a cycle later
	always @(negedge clk) begin
		if (!rst) begin
			check_word("halted", {15'd0, halted}, {15'd0, exp_halted});
			if (exp_wb) begin
				check_word("wb_valid", {15'd0, wb_valid}, 16'd1);
				check_word("wb_reg", {14'd0, wb_reg}, {14'd0, exp_reg});
				check_word("wb_data", wb_data, exp_data);
			end else if (wb_valid !== 1'b0) begin
				$display("Error at %0t: wb_valid strobe with no expected register write", $time);
				other_errors++;
			end
			if (exp_out) begin
				check_word("out_valid", {15'd0, out_valid}, 16'd1);
				check_word("out_data", out_data, exp_data);
			end else if (out_valid !== 1'b0) begin
				$display("Error at %0t: out_valid strobe with no expected WWD", $time);
				other_errors++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`default_nettype none

module tb_top;

	localparam int reset_cycles = 5;
	localparam int random_count = 300;
	localparam int post_halt_count = 8;
	// Worst case of two cycles per draw plus idle, HLT and drain
	localparam int stim_cycles = reset_cycles + 2 * (random_count + post_halt_count) + 8;
	localparam int timeout_cycles = stim_cycles + 20;

	logic clk = 1'b0;
	logic rst;
	logic inst_valid;
	logic [cpu_pkg::word_width-1:0] inst;
	logic wb_valid;
	logic [cpu_pkg::reg_addr_width-1:0] wb_reg;
	logic [cpu_pkg::word_width-1:0] wb_data;
	logic out_valid;
	logic [cpu_pkg::word_width-1:0] out_data;
	logic halted;
	int mismatches;
	int other_errors;
	int cycle_count;

	// 20 unit clock period
	always #10 clk = ~clk;

	cpu_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.halted     (halted)
	);

	// Reference model and comparisons
	tb_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.wb_valid     (wb_valid),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.halted       (halted),
		.mismatches   (mismatches),
		.other_errors (other_errors)
	);

	// One word per cycle on the falling edge
	task automatic drive_word(input logic v, input logic [15:0] w);
		@(negedge clk);
		inst_valid = v;
		inst = w;
	endtask

	// Mostly supported work with some branches and bubbles but never a HLT
	task automatic drive_random();
		logic [15:0] w;
		logic [1:0] rs;
		logic [7:0] imm;
		int kind;
		w = $urandom;
		rs = $urandom;
		imm = $urandom;
		kind = $urandom % 16;
		if (kind < 6) begin
			// R-type ALU funcodes 0 to 7
			drive_word(1'b1, {4'hf, w[11:6], 3'd0, w[2:0]});
		end else if (kind < 10) begin
			// ADI, ORI or LHI
			drive_word(1'b1, {4'd4 + 4'($urandom % 3), w[11:0]});
		end else if (kind == 10) begin
			// Store then load back through the same address
			drive_word(1'b1, {4'd8, rs, w[9:8], imm});
			drive_word(1'b1, {4'd7, rs, w[7:6], imm});
		end else if (kind == 11) begin
			// Lone load or store anywhere in memory
			drive_word(1'b1, {4'd7 + 4'($urandom % 2), w[11:0]});
		end else if (kind == 12) begin
			drive_word(1'b1, {4'hf, w[11:6], 6'd28});
		end else if (kind == 13) begin
			// Branches and jumps
			case ($urandom % 8)
				0, 1, 2, 3: drive_word(1'b1, {4'($urandom % 4), w[11:0]});
				4: drive_word(1'b1, {4'd9, w[11:0]});
				5: drive_word(1'b1, {4'd10, w[11:0]});
				6: drive_word(1'b1, {4'hf, w[11:6], 6'd25});
				default: drive_word(1'b1, {4'hf, w[11:6], 6'd26});
			endcase
		end else begin
			// Bubble with a random word on the bus
			drive_word(1'b0, w);
		end
	endtask

	initial begin
		void'($urandom(64));
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < random_count; i++) begin
			drive_random();
		end
		drive_word(1'b1, {4'hf, 6'd0, 6'd29});
		// Nothing after the HLT may retire
		for (int i = 0; i < post_halt_count; i++) begin
			drive_random();
		end
		drive_word(1'b0, '0);
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		// Drain and stop on a rising edge, clear of the compare edge
		repeat (3) @(posedge clk);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog on the cycle count
	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, halted never went high", cycle_count);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
